/* common/sw_pkg.sv */
package sw_pkg;

	// array size and the S group size
	localparam int PE_NUM = 8;
	localparam int PE_NUM_LOG = 4;

	localparam int BASE_W = 2;
	// eight bases low and the length in the top nibble
	localparam int T_WORD_W = 20;

	localparam int MATCH_W = 4;
	localparam int GAP_W = 8;
	localparam int SCORE_W = 12;

	localparam logic signed [SCORE_W-1:0] NEG_INF = {1'b1, {(SCORE_W-1){1'b0}}};

	// defaults with the penalties already negated
	localparam logic signed [SCORE_W-1:0] DEF_MATCH = 12'sd6;
	localparam logic signed [SCORE_W-1:0] DEF_MISMATCH = -12'sd1;
	localparam logic signed [SCORE_W-1:0] DEF_GAP_OPEN = -12'sd2;
	localparam logic signed [SCORE_W-1:0] DEF_GAP_EXT = -12'sd1;

	// link between neighbouring PEs
	typedef struct packed {
		logic [BASE_W-1:0] base;
		logic valid;
		logic last;
		logic signed [SCORE_W-1:0] h;
		logic signed [SCORE_W-1:0] f;
	} pe_link_t;

endpackage

/* common/score_if.sv */
`timescale 1ns/100ps

interface score_if;
	import sw_pkg::*;

	logic signed [SCORE_W-1:0] match;
	logic signed [SCORE_W-1:0] mismatch;
	logic signed [SCORE_W-1:0] gap_open;
	logic signed [SCORE_W-1:0] gap_ext;
	logic [PE_NUM*BASE_W-1:0] t_bases;
	logic [PE_NUM_LOG-1:0] t_len;

	modport cfg (
		output match, mismatch, gap_open, gap_ext, t_bases, t_len
	);

	// read side stays steady through a run
	modport user (
		input match, mismatch, gap_open, gap_ext, t_bases, t_len
	);

endinterface

/* pe_array/sw_pe.sv */
`timescale 1ns/100ps

module sw_pe (
	input  logic clk,
	input  logic rst_n,
	input  logic i_clear,
	input  logic [sw_pkg::BASE_W-1:0] i_t_base,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_match,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_mismatch,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_gap_open,
	input  logic signed [sw_pkg::SCORE_W-1:0] i_gap_ext,
	input  sw_pkg::pe_link_t i_link,
	output sw_pkg::pe_link_t o_link,
	output logic signed [sw_pkg::SCORE_W-1:0] o_max
);
	import sw_pkg::*;

	logic signed [SCORE_W-1:0] h_prev, e_prev, diag, max_q;
	// one extra bit so NEG_INF plus a penalty cannot wrap
	logic signed [SCORE_W:0] e_open, e_ext, f_open, f_ext, diag_sum;
	logic signed [SCORE_W:0] e_new, f_new, h_new;

	always_comb begin
		e_open = h_prev + i_gap_open;
		e_ext = e_prev + i_gap_ext;
		f_open = i_link.h + i_gap_open;
		f_ext = i_link.f + i_gap_ext;
		diag_sum = diag + ((i_link.base == i_t_base) ? i_match : i_mismatch);
		e_new = (e_open > e_ext) ? e_open : e_ext;
		f_new = (f_open > f_ext) ? f_open : f_ext;
		h_new = '0;
		if (e_new > h_new)
			h_new = e_new;
		if (f_new > h_new)
			h_new = f_new;
		if (diag_sum > h_new)
			h_new = diag_sum;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			h_prev <= '0;
			e_prev <= NEG_INF;
			diag <= '0;
			max_q <= '0;
			o_link <= '0;
		end else if (i_clear) begin
			h_prev <= '0;
			e_prev <= NEG_INF;
			diag <= '0;
			max_q <= '0;
			o_link <= '0;
		end else begin
			o_link.valid <= i_link.valid;
			o_link.last <= i_link.last;
			o_link.base <= i_link.base;
			if (i_link.valid) begin
				o_link.h <= h_new[SCORE_W-1:0];
				o_link.f <= f_new[SCORE_W-1:0];
				h_prev <= h_new[SCORE_W-1:0];
				e_prev <= e_new[SCORE_W-1:0];
				diag <= i_link.h;
				if (h_new > max_q)
					max_q <= h_new[SCORE_W-1:0];
			end
		end
	end

	assign o_max = max_q;

endmodule

/* pe_array/pe_array.sv */
`timescale 1ns/100ps

module pe_array (
	input  logic clk,
	input  logic rst_n,
	input  logic i_start,
	input  sw_pkg::pe_link_t i_link,
	score_if.user sc,
	output logic [sw_pkg::SCORE_W-1:0] o_result,
	output logic o_valid,
	output logic o_done
);
	import sw_pkg::*;

	pe_link_t link [PE_NUM+1];
	logic signed [SCORE_W-1:0] max_w [PE_NUM];
	logic signed [SCORE_W-1:0] best;
	pe_link_t tail;
	logic valid_q;

	assign link[0] = i_link;

	genvar k;
	generate
		for (k = 0; k < PE_NUM; k++) begin : g_pe
			sw_pe u_pe (
				.clk(clk),
				.rst_n(rst_n),
				.i_clear(i_start),
				.i_t_base(sc.t_bases[k*BASE_W +: BASE_W]),
				.i_match(sc.match),
				.i_mismatch(sc.mismatch),
				.i_gap_open(sc.gap_open),
				.i_gap_ext(sc.gap_ext),
				.i_link(link[k]),
				.o_link(link[k+1]),
				.o_max(max_w[k])
			);
		end
	endgenerate

	// output of the last used PE
	assign tail = link[sc.t_len];

	// PEs past t_len are masked out
	always_comb begin
		best = '0;
		for (int i = 0; i < PE_NUM; i++) begin
			if (i < sc.t_len && max_w[i] > best)
				best = max_w[i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_q <= 1'b0;
			o_result <= '0;
		end else begin
			valid_q <= tail.valid && tail.last;
			if (tail.valid && tail.last)
				o_result <= best;
		end
	end

	assign o_valid = valid_q;
	assign o_done = valid_q;

	a_len_set: assert property (@(posedge clk) disable iff (!rst_n)
		i_link.valid |-> sc.t_len != '0);

endmodule

/* hw/s_feeder.sv */
`timescale 1ns/100ps

module s_feeder (
	input  logic clk,
	input  logic rst_n,
	input  logic i_start,
	input  logic [sw_pkg::PE_NUM*sw_pkg::BASE_W-1:0] i_s,
	input  logic [sw_pkg::PE_NUM_LOG-1:0] i_s_valid,
	input  logic i_s_last,
	output logic o_request_s,
	output sw_pkg::pe_link_t o_link
);
	import sw_pkg::*;

	logic [PE_NUM*BASE_W-1:0] sreg;
	logic [PE_NUM_LOG-1:0] cnt;
	logic last_grp;
	logic pending;
	logic grp_in;

	assign grp_in = |i_s_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
			last_grp <= 1'b0;
			pending <= 1'b0;
			o_request_s <= 1'b0;
		end else begin
			o_request_s <= 1'b0;
			if (i_start) begin
				o_request_s <= 1'b1;
				pending <= 1'b1;
			end else if (pending && grp_in) begin
				cnt <= i_s_valid;
				last_grp <= i_s_last;
				pending <= 1'b0;
			end else if (cnt != '0) begin
				cnt <= cnt - 1'b1;
				// final base of a non-last group goes out now
				if (cnt == 1 && !last_grp) begin
					o_request_s <= 1'b1;
					pending <= 1'b1;
				end
			end
		end
	end

	// lowest base leaves first
	always_ff @(posedge clk) begin
		if (pending && grp_in)
			sreg <= i_s;
		else if (cnt != '0)
			sreg <= sreg >> BASE_W;
	end

	always_comb begin
		o_link.base = sreg[BASE_W-1:0];
		o_link.valid = (cnt != '0);
		o_link.last = last_grp && (cnt == 1);
		o_link.h = '0;
		o_link.f = NEG_INF;
	end

	a_group_expected: assert property (@(posedge clk) disable iff (!rst_n)
		grp_in |-> (cnt == '0) && pending);

endmodule

/* hw/sw_align_top.sv */
`timescale 1ns/100ps

module sw_align_top (
	input  logic clk,
	input  logic rst_n,
	input  logic i_set_t,
	input  logic [sw_pkg::T_WORD_W-1:0] i_t,
	input  logic i_start_cal,
	input  logic [sw_pkg::PE_NUM*sw_pkg::BASE_W-1:0] i_s,
	input  logic [sw_pkg::PE_NUM_LOG-1:0] i_s_valid,
	input  logic i_s_last,
	input  logic [sw_pkg::MATCH_W-1:0] i_match,
	input  logic [sw_pkg::MATCH_W-1:0] i_mismatch,
	input  logic [sw_pkg::GAP_W-1:0] i_gap_open,
	input  logic [sw_pkg::GAP_W-1:0] i_gap_ext,
	input  logic i_param_valid,
	output logic o_busy,
	output logic o_request_s,
	output logic [sw_pkg::SCORE_W-1:0] o_result,
	output logic o_valid
);
	import sw_pkg::*;

	typedef enum logic [1:0] {IDLE, SETT, CALC, RESET} state_t;

	state_t state, n_state;

	// input stage
	logic set_t_r, start_cal_r, s_last_r, param_valid_r;
	logic [PE_NUM_LOG-1:0] s_valid_r;
	logic [T_WORD_W-1:0] t_r;
	logic [PE_NUM*BASE_W-1:0] s_r;
	logic [MATCH_W-1:0] match_r, mismatch_r;
	logic [GAP_W-1:0] gap_open_r, gap_ext_r;

	logic signed [SCORE_W-1:0] match_p, mismatch_p, gap_open_p, gap_ext_p;
	logic [PE_NUM*BASE_W-1:0] t_bases;
	logic [PE_NUM_LOG-1:0] t_len;

	logic start_cal, arr_clear, arr_done;
	pe_link_t feed_link;

	score_if u_sc ();

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			set_t_r <= 1'b0;
			start_cal_r <= 1'b0;
			s_valid_r <= '0;
			s_last_r <= 1'b0;
			param_valid_r <= 1'b0;
		end else begin
			set_t_r <= i_set_t;
			start_cal_r <= i_start_cal;
			s_valid_r <= i_s_valid;
			s_last_r <= i_s_last;
			param_valid_r <= i_param_valid;
		end
	end

	always_ff @(posedge clk) begin
		t_r <= i_t;
		s_r <= i_s;
		match_r <= i_match;
		mismatch_r <= i_mismatch;
		gap_open_r <= i_gap_open;
		gap_ext_r <= i_gap_ext;
	end

	always_comb begin
		n_state = state;
		case (state)
			IDLE: begin
				if (set_t_r)
					n_state = SETT;
				else if (start_cal_r && t_len != '0)
					n_state = CALC;
			end
			SETT: n_state = IDLE;
			CALC: begin
				if (arr_done)
					n_state = RESET;
			end
			RESET: n_state = IDLE;
			default: n_state = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
			o_busy <= 1'b0;
			start_cal <= 1'b0;
			t_bases <= '0;
			t_len <= '0;
		end else begin
			state <= n_state;
			o_busy <= (n_state == SETT) || (n_state == CALC);
			start_cal <= (state == IDLE) && (n_state == CALC);
			if (state == IDLE && set_t_r) begin
				t_bases <= t_r[PE_NUM*BASE_W-1:0];
				t_len <= t_r[T_WORD_W-1 -: PE_NUM_LOG];
			end
		end
	end

	// magnitudes in, negated penalties out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			match_p <= DEF_MATCH;
			mismatch_p <= DEF_MISMATCH;
			gap_open_p <= DEF_GAP_OPEN;
			gap_ext_p <= DEF_GAP_EXT;
		end else if (param_valid_r && state != CALC) begin
			match_p <= $signed({{(SCORE_W-MATCH_W){1'b0}}, match_r});
			mismatch_p <= -$signed({{(SCORE_W-MATCH_W){1'b0}}, mismatch_r});
			gap_open_p <= -$signed({{(SCORE_W-GAP_W){1'b0}}, gap_open_r});
			gap_ext_p <= -$signed({{(SCORE_W-GAP_W){1'b0}}, gap_ext_r});
		end
	end

	assign u_sc.match = match_p;
	assign u_sc.mismatch = mismatch_p;
	assign u_sc.gap_open = gap_open_p;
	assign u_sc.gap_ext = gap_ext_p;
	assign u_sc.t_bases = t_bases;
	assign u_sc.t_len = t_len;

	// maximums cleared at run start and again in RESET
	assign arr_clear = start_cal | (state == RESET);

	s_feeder u_feeder (
		.clk(clk),
		.rst_n(rst_n),
		.i_start(start_cal),
		.i_s(s_r),
		.i_s_valid(s_valid_r),
		.i_s_last(s_last_r),
		.o_request_s(o_request_s),
		.o_link(feed_link)
	);

	pe_array u_array (
		.clk(clk),
		.rst_n(rst_n),
		.i_start(arr_clear),
		.i_link(feed_link),
		.sc(u_sc),
		.o_result(o_result),
		.o_valid(o_valid),
		.o_done(arr_done)
	);

	a_valid_in_calc: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |-> state == CALC);

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// low over the first three rising edges
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		#2 rst_n = 1'b1;
	end

endmodule

/* testbench/tb_sw_align.sv */
`timescale 1ns/100ps

module tb_sw_align;
	import sw_pkg::*;

	localparam int LIMIT = 300;
	localparam int NEG = -100000;

	logic clk, rst_n;
	logic i_set_t, i_start_cal, i_s_last, i_param_valid;
	logic [T_WORD_W-1:0] i_t;
	logic [PE_NUM*BASE_W-1:0] i_s;
	logic [PE_NUM_LOG-1:0] i_s_valid;
	logic [MATCH_W-1:0] i_match, i_mismatch;
	logic [GAP_W-1:0] i_gap_open, i_gap_ext;
	logic o_busy, o_request_s, o_valid;
	logic [SCORE_W-1:0] o_result;

	logic [31:0] lfsr = 32'h66fd_3105;
	logic [1:0] t_seq [PE_NUM];
	logic [1:0] s_seq [64];
	int t_len, s_len;
	// accepted parameters as signed scores starting at the reset defaults
	int p_match = 6, p_mismatch = -1, p_open = -2, p_ext = -1;
	int exp_score;
	int runs = 0;
	int pulses = 0;
	int lens [4] = '{1, 8, 16, 23};

	tb_clock u_clk (.*);

	sw_align_top u_dut (.*);

	task automatic tick();
		@(posedge clk);
		#2;
	endtask

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "stopped at the first failure");
	endtask

	task automatic check_value(input string name, input int got, input int exp);
		if (got != exp)
			stop_run($sformatf("[ERROR] %0d ns %s got %0d expected %0d",
				$time, name, got, exp));
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic int take_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_step(lfsr);
			v = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	function automatic int max2(input int a, input int b);
		return (a > b) ? a : b;
	endfunction

	// affine local alignment with query bases as rows and one column of S per step
	function automatic int ref_score();
		int h_left [PE_NUM];
		int e_row [PE_NUM];
		int best, h_up, f_up, diag, e, f, h;
		best = 0;
		for (int i = 0; i < PE_NUM; i++) begin
			h_left[i] = 0;
			e_row[i] = NEG;
		end
		for (int j = 0; j < s_len; j++) begin
			h_up = 0;
			f_up = NEG;
			diag = 0;
			for (int i = 0; i < t_len; i++) begin
				e = max2(h_left[i] + p_open, e_row[i] + p_ext);
				f = max2(h_up + p_open, f_up + p_ext);
				h = max2(diag + ((t_seq[i] == s_seq[j]) ? p_match : p_mismatch), 0);
				h = max2(h, max2(e, f));
				diag = h_left[i];
				h_left[i] = h;
				e_row[i] = e;
				h_up = h;
				f_up = f;
				best = max2(best, h);
			end
		end
		return best;
	endfunction

	task automatic set_params(input int ma, input int mm, input int go, input int ge);
		i_match = MATCH_W'(ma);
		i_mismatch = MATCH_W'(mm);
		i_gap_open = GAP_W'(go);
		i_gap_ext = GAP_W'(ge);
		i_param_valid = 1'b1;
		tick();
		i_param_valid = 1'b0;
		tick();
		tick();
		p_match = ma;
		p_mismatch = -mm;
		p_open = -go;
		p_ext = -ge;
	endtask

	task automatic wait_busy(input logic level, input string what);
		int n;
		n = 0;
		while (o_busy !== level) begin
			tick();
			n++;
			if (n > LIMIT)
				stop_run({"timeout waiting for o_busy ", what});
		end
	endtask

	task automatic load_query(input int len);
		logic [T_WORD_W-1:0] word;
		t_len = len;
		word = '0;
		for (int i = 0; i < PE_NUM; i++) begin
			t_seq[i] = 2'(take_bits(2));
			word[i*BASE_W +: BASE_W] = t_seq[i];
		end
		word[T_WORD_W-1 -: PE_NUM_LOG] = PE_NUM_LOG'(len);
		i_t = word;
		i_set_t = 1'b1;
		tick();
		i_set_t = 1'b0;
		wait_busy(1'b1, "to rise for the query load");
		wait_busy(1'b0, "to fall after the query load");
	endtask

	task automatic run_scan(input int len, input bit mid_params);
		logic [PE_NUM*BASE_W-1:0] grp;
		int sent, cnt, n;
		s_len = len;
		for (int j = 0; j < len; j++)
			s_seq[j] = 2'(take_bits(2));
		exp_score = ref_score();
		runs++;
		i_start_cal = 1'b1;
		tick();
		i_start_cal = 1'b0;
		sent = 0;
		while (sent < len) begin
			n = 0;
			while (o_request_s !== 1'b1) begin
				tick();
				n++;
				if (n > LIMIT)
					stop_run("no request came for the next group of S");
			end
			repeat (take_bits(2)) tick();
			cnt = (len - sent > PE_NUM) ? PE_NUM : len - sent;
			grp = '0;
			for (int k = 0; k < cnt; k++)
				grp[k*BASE_W +: BASE_W] = s_seq[sent+k];
			i_s = grp;
			i_s_valid = PE_NUM_LOG'(cnt);
			i_s_last = (sent + cnt == len);
			tick();
			i_s_valid = '0;
			i_s_last = 1'b0;
			if (mid_params && sent == 0) begin
				// lands while the run is in CALC
				i_match = 4'd15;
				i_mismatch = 4'd15;
				i_gap_open = 8'd200;
				i_gap_ext = 8'd200;
				i_param_valid = 1'b1;
				tick();
				i_param_valid = 1'b0;
			end
			sent += cnt;
		end
		n = 0;
		while (pulses != runs) begin
			tick();
			n++;
			if (n > LIMIT)
				stop_run("timeout waiting for o_valid");
		end
		wait_busy(1'b0, "to fall after the run");
		// RESET state, then IDLE
		tick();
		tick();
	endtask

	initial begin : result_check
		forever begin
			tick();
			if (o_valid === 1'b1) begin
				pulses++;
				check_value("o_valid count", pulses, runs);
				check_value("o_result", int'(o_result), exp_score);
				check_value("o_busy", int'(o_busy), 1);
				tick();
				check_value("o_valid", int'(o_valid), 0);
				check_value("o_busy", int'(o_busy), 0);
			end
		end
	end

	initial begin : stimulus
		int n;
		i_set_t = 1'b0;
		i_t = '0;
		i_start_cal = 1'b0;
		i_s = '0;
		i_s_valid = '0;
		i_s_last = 1'b0;
		i_match = '0;
		i_mismatch = '0;
		i_gap_open = '0;
		i_gap_ext = '0;
		i_param_valid = 1'b0;
		n = 0;
		while (rst_n !== 1'b1) begin
			tick();
			n++;
			if (n > LIMIT)
				stop_run("reset was never released");
		end
		tick();
		check_value("o_busy", int'(o_busy), 0);
		check_value("o_valid", int'(o_valid), 0);
		check_value("o_request_s", int'(o_request_s), 0);
		load_query(1 + take_bits(3));
		run_scan(1 + take_bits(5), 1'b0);
		repeat (20) begin
			set_params(take_bits(4), take_bits(4), take_bits(5), take_bits(3));
			load_query(1 + take_bits(3));
			run_scan(1 + take_bits(5), 1'b0);
		end
		// strobe during CALC must leave both runs on the old values
		load_query(8);
		run_scan(20, 1'b1);
		load_query(1 + take_bits(3));
		run_scan(12, 1'b0);
		foreach (lens[i]) begin
			load_query(1 + take_bits(3));
			run_scan(lens[i], 1'b0);
		end
		load_query(0);
		i_start_cal = 1'b1;
		tick();
		i_start_cal = 1'b0;
		repeat (50) begin
			tick();
			check_value("o_busy", int'(o_busy), 0);
			check_value("o_request_s", int'(o_request_s), 0);
		end
		set_params(6, 1, 2, 1);
		repeat (4) begin
			load_query(1 + take_bits(3));
			run_scan(1 + take_bits(5), 1'b0);
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

/* sw_align.f */
common/sw_pkg.sv
common/score_if.sv
pe_array/sw_pe.sv
pe_array/pe_array.sv
hw/s_feeder.sv
hw/sw_align_top.sv
testbench/tb_clock.sv
testbench/tb_sw_align.sv

/* Makefile */
TOP := tb_sw_align

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module $(TOP) -f sw_align.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
